/* flist.f */
imul_pkg.sv
imul_dpath.sv
imul_unit.sv
imul_dispatch.sv
resp_arbiter.sv
imul_cluster.sv
imul_assertions.sv
tb_imul_cluster.sv

/* tb_imul_cluster.sv */
// --------------------
// testbench for the multiply cluster with a table of signed products and a tag scoreboard
// covers reset state, back-to-back dispatch, hold-off under back-pressure and random stalls
// --------------------
`timescale 1ns/1ps

module tb_imul_cluster;

  import imul_pkg::*;

  localparam int NUM_VECS       = 16;
  localparam int TIMEOUT_CYCLES = NUM_VECS * 40 + 200;
  localparam int STALL_LEN      = 1024;
  localparam int NUM_TAGS       = 2 ** $bits(tag_t);

  // one row of the stimulus table
  typedef struct packed {
    tag_t     tag;
    operand_t a;
    operand_t b;
    product_t expected;
    logic     stall;
  } vec_t;

  // response side behavior
  typedef enum logic [1:0] {
    RDY_HOLD,
    RDY_ALWAYS,
    RDY_RANDOM
  } rdy_mode_t;

  logic      clk;
  logic      reset;
  mul_req_t  req_msg;
  logic      req_val;
  logic      req_rdy;
  mul_resp_t resp_msg;
  logic      resp_val;
  logic      resp_rdy;

  vec_t      vecs [NUM_VECS];
  int        num_loaded;
  // scoreboard indexed by tag
  product_t  exp_by_tag [NUM_TAGS];
  bit        issued [NUM_TAGS];
  int        seen [NUM_TAGS];
  int        accept_cycle [NUM_VECS];
  bit        stall_pat [STALL_LEN];
  rdy_mode_t rdy_mode = RDY_HOLD;
  int        resp_count = 0;
  int        cycle = 0;
  bit        all_seen;

  imul_cluster imul_cluster_inst (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // top-level handshake checks plus per-unit hold checks on the internal wires
  bind imul_cluster imul_assertions assertions_inst (
    .clk           (clk),
    .reset         (reset),
    .req_msg       (req_msg),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .resp_msg      (resp_msg),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .unit_resp_msg (unit_resp_msg),
    .unit_resp_val (unit_resp_val),
    .unit_resp_rdy (unit_resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // tag follows the row index
  task automatic add_vec(input operand_t a, input operand_t b,
                         input product_t expected, input logic stall);
    vecs[num_loaded] = '{tag: tag_t'(num_loaded), a: a, b: b, expected: expected, stall: stall};
    num_loaded++;
  endtask

  task automatic load_table();
    operand_t ra;
    operand_t rb;
    longint   pa;
    longint   pb;
    num_loaded = 0;
    // corner cases with products worked out by hand
    add_vec(0, 12345, 0, 1'b0);
    add_vec(1, -1, -1, 1'b0);
    add_vec(-1, -1, 1, 1'b0);
    add_vec(32'h8000_0000, -1, 64'h0000_0000_8000_0000, 1'b1);
    add_vec(32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000, 1'b0);
    add_vec(7, -6, -42, 1'b1);
    add_vec(-123, 456, -56088, 1'b1);
    add_vec(32'h7fff_ffff, 32'h7fff_ffff, 64'h3fff_ffff_0000_0001, 1'b0);
    add_vec(32'h7fff_ffff, 32'h8000_0000, 64'hc000_0000_8000_0000, 1'b1);
    add_vec(65536, 65536, 64'h0000_0001_0000_0000, 1'b1);
    add_vec(-100000, -100000, 64'd10000000000, 1'b0);
    add_vec(1, 32'h8000_0000, 64'hffff_ffff_8000_0000, 1'b1);
    // random operands fill the rest and are sign extended to 64 bits for the multiply
    while (num_loaded < NUM_VECS) begin
      ra = $urandom;
      rb = $urandom;
      pa = ra;
      pb = rb;
      add_vec(ra, rb, pa * pb, 1'b1);
    end
    // roughly three ready cycles in four
    for (int k = 0; k < STALL_LEN; k++) begin
      stall_pat[k] = ($urandom % 4) != 0;
    end
  endtask

  task automatic drive_req(input int idx);
    @(negedge clk);
    req_msg = '{tag: vecs[idx].tag, a: vecs[idx].a, b: vecs[idx].b};
    req_val = 1'b1;
    exp_by_tag[vecs[idx].tag] = vecs[idx].expected;
    issued[vecs[idx].tag] = 1'b1;
  endtask

  // returns at the edge where the request transfers
  task automatic send(input int idx);
    drive_req(idx);
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    accept_cycle[idx] = cycle;
  endtask

  // --------------------
  // background processes
  // --------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d responses returned",
               cycle, resp_count, NUM_VECS);
      $display("SIMULATION FAILED");
      $fatal(1, "run did not finish in time");
    end
  end

  always @(negedge clk) begin
    case (rdy_mode)
      RDY_HOLD:   resp_rdy = 1'b0;
      RDY_ALWAYS: resp_rdy = 1'b1;
      default:    resp_rdy = stall_pat[cycle % STALL_LEN];
    endcase
  end

  // response monitor scores each transfer by its tag
  always @(posedge clk) begin
    tag_t t;
    if (!reset && resp_val && resp_rdy) begin
      t = resp_msg.tag;
      check($sformatf("tag %0d was issued", t), 1, issued[t]);
      check($sformatf("tag %0d returned once", t), 0, seen[t]);
      check($sformatf("product for tag %0d", t), exp_by_tag[t], resp_msg.product);
      seen[t]    <= seen[t] + 1;
      resp_count <= resp_count + 1;
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    void'($urandom(32'h1b85));
    reset   = 1'b1;
    req_val = 1'b0;
    req_msg = '0;
    resp_rdy = 1'b0;
    load_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    check("req_rdy after reset", 1, req_rdy);
    check("resp_val after reset", 0, resp_val);
    // rows 0 and 1 fill both units while the response side is held
    for (int i = 0; i < NUM_VECS; i++) begin
      if (i == 2) begin
        drive_req(2);
        // third request must wait while both units are busy and stalled
        repeat (40) begin
          @(posedge clk);
          check("third request held off", 0, req_rdy);
        end
        rdy_mode = RDY_ALWAYS;
      end else if (i > 2) begin
        rdy_mode = vecs[i].stall ? RDY_RANDOM : RDY_ALWAYS;
      end
      send(i);
      if (i == 1) begin
        check("second request back to back", accept_cycle[0] + 1, accept_cycle[1]);
      end
      if (i == 2) begin
        check("third request after a response", 1, resp_count >= 1);
      end
    end
    @(negedge clk);
    req_val = 1'b0;
    while (resp_count < NUM_VECS) begin
      @(posedge clk);
    end
    // a few idle cycles to catch a duplicate
    repeat (5) @(posedge clk);
    check("response count", NUM_VECS, resp_count);
    all_seen = 1'b1;
    for (int t = 0; t < NUM_VECS; t++) begin
      if (seen[t] != 1) begin
        all_seen = 1'b0;
      end
    end
    if (all_seen) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "not every tag came back exactly once");
    end
  end

endmodule

/* imul_assertions.sv */
// --------------------
// concurrent handshake checks bound into imul_cluster
// --------------------
`timescale 1ns/1ps

module imul_assertions (
  input logic                           clk,
  input logic                           reset,
  input imul_pkg::mul_req_t             req_msg,
  input logic                           req_val,
  input logic                           req_rdy,
  input imul_pkg::mul_resp_t            resp_msg,
  input logic                           resp_val,
  input logic                           resp_rdy,
  input imul_pkg::mul_resp_t            unit_resp_msg [imul_pkg::NUM_UNITS],
  input logic [imul_pkg::NUM_UNITS-1:0] unit_resp_val,
  input logic [imul_pkg::NUM_UNITS-1:0] unit_resp_rdy
);

  import imul_pkg::*;

  // no response on the bus right after reset
  resp_idle_after_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

  // sender keeps the request steady until it transfers
  req_held: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req_msg)))
    else $error("request changed or dropped before transfer");

  // a stalled bus keeps the same response offered
  resp_held: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)))
    else $error("response changed or dropped under back-pressure");

  // each waiting unit holds its own tag and product
  for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit_hold
    unit_resp_held: assert property (@(posedge clk) disable iff (reset)
      (unit_resp_val[i] && !unit_resp_rdy[i]) |=>
        (unit_resp_val[i] && $stable(unit_resp_msg[i])))
      else $error("unit %0d changed its response while waiting", i);
  end

endmodule

/* imul_cluster.sv */
// --------------------
// multiply cluster top: dispatcher, NUM_UNITS multiplier units, response arbiter
// one val/rdy request port in, one val/rdy response port out, tags reorder
// --------------------
`timescale 1ns/1ps

module imul_cluster (
  input  logic                clk,
  input  logic                reset,
  input  imul_pkg::mul_req_t  req_msg,
  input  logic                req_val,
  output logic                req_rdy,
  output imul_pkg::mul_resp_t resp_msg,
  output logic                resp_val,
  input  logic                resp_rdy
);

  import imul_pkg::*;

  // --------------------
  // internal wiring
  // --------------------

  // dispatcher to units
  mul_req_t             unit_req_msg;
  logic [NUM_UNITS-1:0] unit_req_val;
  logic [NUM_UNITS-1:0] unit_req_rdy;

  // units to arbiter
  mul_resp_t            unit_resp_msg [NUM_UNITS];
  logic [NUM_UNITS-1:0] unit_resp_val;
  logic [NUM_UNITS-1:0] unit_resp_rdy;

  imul_dispatch dispatch_inst (
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .unit_req_rdy (unit_req_rdy),
    .unit_req_val (unit_req_val),
    .unit_req_msg (unit_req_msg)
  );

  // peer units share the request message, each with its own handshakes
  for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
    imul_unit unit_inst (
      .clk     (clk),
      .reset   (reset),
      .in_msg  (unit_req_msg),
      .in_val  (unit_req_val[i]),
      .in_rdy  (unit_req_rdy[i]),
      .out_msg (unit_resp_msg[i]),
      .out_val (unit_resp_val[i]),
      .out_rdy (unit_resp_rdy[i])
    );
  end

  resp_arbiter arbiter_inst (
    .clk           (clk),
    .reset         (reset),
    .unit_resp_msg (unit_resp_msg),
    .unit_resp_val (unit_resp_val),
    .unit_resp_rdy (unit_resp_rdy),
    .resp_msg      (resp_msg),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy)
  );

endmodule

/* resp_arbiter.sv */
// --------------------
// round-robin arbiter onto the shared response bus
// the grant is combinational and the pointer moves past the winner on each transfer
// --------------------
`timescale 1ns/1ps

module resp_arbiter (
  input  logic                           clk,
  input  logic                           reset,
  input  imul_pkg::mul_resp_t            unit_resp_msg [imul_pkg::NUM_UNITS],
  input  logic [imul_pkg::NUM_UNITS-1:0] unit_resp_val,
  output logic [imul_pkg::NUM_UNITS-1:0] unit_resp_rdy,
  output imul_pkg::mul_resp_t            resp_msg,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  import imul_pkg::*;

  // first unit to consider this cycle
  unit_idx_t ptr;
  unit_idx_t ptr_next;

  unit_idx_t grant_idx;
  logic      grant_any;

  // --------------------
  // grant search
  // --------------------

  // walk the ring from the pointer and take the first valid unit
  always_comb begin
    int cand;
    grant_any = 1'b0;
    grant_idx = '0;
    for (int off = 0; off < NUM_UNITS; off++) begin
      cand = (int'(ptr) + off) % NUM_UNITS;
      if (unit_resp_val[cand] && !grant_any) begin
        grant_any = 1'b1;
        grant_idx = unit_idx_t'(cand);
      end
    end
  end

  // --------------------
  // bus and handshakes
  // --------------------

  assign resp_val = grant_any;
  assign resp_msg = unit_resp_msg[grant_idx];

  // only the granted unit sees rdy, and only when the bus is taken
  always_comb begin
    unit_resp_rdy = '0;
    if (grant_any && resp_rdy) begin
      unit_resp_rdy[grant_idx] = 1'b1;
    end
  end

  // next turn starts just after the winner and wraps at the top
  assign ptr_next = (int'(grant_idx) == NUM_UNITS - 1) ? '0 : grant_idx + unit_idx_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (resp_val && resp_rdy) begin
      ptr <= ptr_next;
    end else if (resp_val) begin
      // park on a stalled winner so the offered response cannot switch
      ptr <= grant_idx;
    end
  end

endmodule

/* imul_dispatch.sv */
// --------------------
// request dispatcher, purely combinational
// steers each external request to the lowest-numbered idle unit
// --------------------
`timescale 1ns/1ps

module imul_dispatch (
  input  imul_pkg::mul_req_t               req_msg,
  input  logic                             req_val,
  output logic                             req_rdy,
  input  logic [imul_pkg::NUM_UNITS-1:0]   unit_req_rdy,
  output logic [imul_pkg::NUM_UNITS-1:0]   unit_req_val,
  output imul_pkg::mul_req_t               unit_req_msg
);

  import imul_pkg::*;

  // one-hot pick of the lowest idle unit, zero when all are busy
  logic [NUM_UNITS-1:0] pick;

  // --------------------
  // priority encoder
  // --------------------

  always_comb begin
    logic found;
    found = 1'b0;
    pick  = '0;
    // scan upward so unit 0 wins ties
    for (int i = 0; i < NUM_UNITS; i++) begin
      if (unit_req_rdy[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
  end

  // --------------------
  // handshake steering
  // --------------------

  // any idle unit can take the next request
  assign req_rdy = |unit_req_rdy;

  // valid reaches only the chosen unit
  assign unit_req_val = pick & {NUM_UNITS{req_val}};

  // message fans out to every unit, only the selected one loads it
  assign unit_req_msg = req_msg;

endmodule

/* imul_unit.sv */
// --------------------
// one iterative signed multiplier unit with val/rdy on both sides
// idle -> 32 calc cycles -> holds the response until it is taken
// --------------------
`timescale 1ns/1ps

module imul_unit (
  input  logic                clk,
  input  logic                reset,
  input  imul_pkg::mul_req_t  in_msg,
  input  logic                in_val,
  output logic                in_rdy,
  output imul_pkg::mul_resp_t out_msg,
  output logic                out_val,
  input  logic                out_rdy
);

  import imul_pkg::*;

  // --------------------
  // control FSM
  // --------------------

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t state;
  state_t state_next;

  logic     load;
  logic     step;
  logic     last_iter;
  tag_t     tag_q;
  product_t result;

  // the dispatcher only raises in_val toward an idle unit,
  // so the valid alone starts the multiply
  assign load = in_val;

  // one shift-add per cycle while calculating
  assign step = (state == CALC);

  // handshake flags follow the state directly
  assign in_rdy  = (state == IDLE);
  assign out_val = (state == DONE);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (in_val) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // step 32 is the one with last_iter high
        if (last_iter) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // hold the response through any back-pressure
        if (out_rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // tag rides alongside the calculation
  always_ff @(posedge clk) begin
    if (load) begin
      tag_q <= in_msg.tag;
    end
  end

  // --------------------
  // datapath
  // --------------------

  imul_dpath dpath_inst (
    .clk       (clk),
    .reset     (reset),
    .a         (in_msg.a),
    .b         (in_msg.b),
    .load      (load),
    .step      (step),
    .result    (result),
    .last_iter (last_iter)
  );

  // response pairs the held tag with the signed product
  assign out_msg = '{tag: tag_q, product: result};

endmodule

/* imul_dpath.sv */
// --------------------
// shift-add multiply datapath working on operand magnitudes
// driven by load and step from the unit FSM, sign restored at the output
// --------------------
`timescale 1ns/1ps

module imul_dpath (
  input  logic               clk,
  input  logic               reset,
  input  imul_pkg::operand_t a,
  input  imul_pkg::operand_t b,
  input  logic               load,
  input  logic               step,
  output imul_pkg::product_t result,
  output logic               last_iter
);

  import imul_pkg::*;

  // --------------------
  // operand magnitudes
  // --------------------

  logic [31:0] a_mag;
  logic [31:0] b_mag;

  // two's complement negate when the sign bit is set
  // the minimum integer maps to 0x80000000, which is still the right magnitude
  assign a_mag = a[31] ? (~a + 32'd1) : a;
  assign b_mag = b[31] ? (~b + 32'd1) : b;

  // --------------------
  // state registers
  // --------------------

  // multiplicand, widened so it can shift into the upper word
  product_t    a_reg;
  // multiplier, consumed one bit per step from the bottom
  logic [31:0] b_reg;
  // running sum of partial products
  product_t    acc;
  // product sign, xor of the operand signs
  logic        neg_q;
  // steps left, zero on the final step
  iter_t       count;

  // partial product for this step, zero when the multiplier bit is clear
  product_t    addend;

  assign addend = b_reg[0] ? a_reg : '0;

  // payload registers load on request and advance on each step
  always_ff @(posedge clk) begin
    if (load) begin
      a_reg <= {32'd0, a_mag};
      b_reg <= b_mag;
      acc   <= '0;
      neg_q <= a[31] ^ b[31];
    end else if (step) begin
      acc   <= acc + addend;
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // iteration counter
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      // first step sees MUL_ITERS-1, last step sees zero
      count <= iter_t'(MUL_ITERS - 1);
    end else if (step) begin
      // wraps after the final step, harmless since the FSM leaves CALC
      count <= count - iter_t'(1);
    end
  end

  // --------------------
  // outputs
  // --------------------

  // high during the step that completes the product
  assign last_iter = (count == '0);

  // restore the sign of the magnitude product
  assign result = neg_q ? (~acc + 64'sd1) : acc;

endmodule

/* imul_pkg.sv */
// --------------------
// shared widths, typedefs and message structs for the multiply cluster
// import inside a module body, or use scoped names in port lists
// --------------------
package imul_pkg;

  // --------------------
  // sizes
  // --------------------

  // number of peer multiplier units behind the dispatcher
  localparam int NUM_UNITS = 2;

  // one iteration per multiplier bit
  localparam int MUL_ITERS = 32;

  // wide enough to name any unit, at least one bit
  localparam int UNIT_IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

  // --------------------
  // plain vector types
  // --------------------

  // one signed word
  typedef logic signed [31:0] operand_t;

  // double word product
  typedef logic signed [63:0] product_t;

  // request identifier, echoed back with the product
  typedef logic [3:0] tag_t;

  // counts down the shift-add steps
  typedef logic [4:0] iter_t;

  // names one multiplier unit
  typedef logic [UNIT_IDX_W-1:0] unit_idx_t;

  // --------------------
  // messages
  // --------------------

  // request, 68 bits
  typedef struct packed {
    tag_t     tag;
    operand_t a;
    operand_t b;
  } mul_req_t;

  // response, 68 bits
  typedef struct packed {
    tag_t     tag;
    product_t product;
  } mul_resp_t;

endpackage
